/* src/nes_bus_pkg.sv */
package nes_bus_pkg;

    // CPU bus widths
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // PPU register selects, 0..7 follow the low address bits
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } ppu_reg_t;

    // One request from the CPU side
    typedef struct packed {
        addr_t addr;
        logic  r_en;
        data_t w_data;
    } cpu_bus_t;

    // One-hot target decode, all zero when unmapped
    typedef struct packed {
        logic ram_sel;
        logic prom_sel;
        logic ppu_sel;
        logic joy_sel;
    } bus_sel_t;

    typedef struct packed {
        ppu_reg_t reg_sel;
        logic     reg_en;
        logic     reg_rw;
        data_t    reg_data_wr;
    } ppu_port_t;

    localparam addr_t JOY1_ADDR   = 16'h4016;
    localparam addr_t OAMDMA_ADDR = 16'h4014;

    localparam int CTRL_PULSE_LEN = 3;
    localparam int RAM_ADDR_W     = 11;
    localparam int PROM_ADDR_W    = 14;
    localparam string PROM_FILE   = "prg_rom.hex";

endpackage : nes_bus_pkg

/* src/bus_decoder.sv */
`timescale 1ns/100ps

module bus_decoder (
    input  nes_bus_pkg::addr_t    addr,
    output nes_bus_pkg::bus_sel_t sel,
    output nes_bus_pkg::ppu_reg_t ppu_reg
);
    import nes_bus_pkg::*;

    logic ppu_window;

    // 0x2000-0x3FFF, registers repeat every 8 bytes
    assign ppu_window = (addr[15:13] == 3'b001);

    always_comb begin
        sel = '0;
        sel.ram_sel  = (addr[15:13] == 3'b000);
        sel.prom_sel = (addr[15:14] == 2'b11);
        sel.ppu_sel  = ppu_window || (addr == OAMDMA_ADDR);
        sel.joy_sel  = (addr == JOY1_ADDR);
    end

    always_comb begin
        ppu_reg = PPUCTRL;
        if (ppu_window) begin
            case (addr[2:0])
                3'h0: ppu_reg = PPUCTRL;
                3'h1: ppu_reg = PPUMASK;
                3'h2: ppu_reg = PPUSTATUS;
                3'h3: ppu_reg = OAMADDR;
                3'h4: ppu_reg = OAMDATA;
                3'h5: ppu_reg = PPUSCROLL;
                3'h6: ppu_reg = PPUADDR;
                default: ppu_reg = PPUDATA;
            endcase
        end
        else if (addr == OAMDMA_ADDR) begin
            ppu_reg = OAMDMA;
        end
    end

endmodule : bus_decoder

/* src/work_ram.sv */
`timescale 1ns/100ps

module work_ram (
    input  logic                               clock,
    input  logic                               clock_en,
    input  logic                               sel,
    input  logic                               r_en,
    input  logic [nes_bus_pkg::RAM_ADDR_W-1:0] addr,
    input  nes_bus_pkg::data_t                 w_data,
    output nes_bus_pkg::data_t                 r_data
);
    import nes_bus_pkg::*;

    // Upper CPU address bits never reach here, so the 2 KiB mirrors
    data_t mem [2**RAM_ADDR_W];

    always_ff @(posedge clock) begin
        if (clock_en && sel) begin
            if (r_en) begin
                r_data <= mem[addr];
            end
            else begin
                mem[addr] <= w_data;
            end
        end
    end

endmodule : work_ram

/* src/prg_rom.sv */
`timescale 1ns/100ps

module prg_rom (
    input  logic                                clock,
    input  logic                                clock_en,
    input  logic [nes_bus_pkg::PROM_ADDR_W-1:0] addr,
    output nes_bus_pkg::data_t                  r_data
);
    import nes_bus_pkg::*;

    data_t mem [2**PROM_ADDR_W];

    // Cartridge image, fixed at load time
    initial begin
        $readmemh(PROM_FILE, mem);
    end

    // Read every enabled edge, the return path decides whether it is used
    always_ff @(posedge clock) begin
        if (clock_en) begin
            r_data <= mem[addr];
        end
    end

endmodule : prg_rom

/* src/joypad_port.sv */
`timescale 1ns/100ps

module joypad_port (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  clock_en,
    input  nes_bus_pkg::cpu_bus_t bus,
    input  logic                  joy_sel,
    input  logic                  ctlr_data,
    output logic                  ctlr_latch,
    output logic                  ctlr_pulse,
    output nes_bus_pkg::data_t    button_bit
);
    import nes_bus_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WROTE1,
        WROTE0,
        PULSE_LO,
        PULSE_HI
    } joy_state_t;

    joy_state_t curr, next;

    logic [$clog2(CTRL_PULSE_LEN+1)-1:0] phase_cnt;
    logic [3:0] read_cnt;
    logic       joy_wr;
    logic       joy_rd;
    logic       phase_done;

    assign joy_wr     = joy_sel && !bus.r_en;
    assign joy_rd     = joy_sel && bus.r_en;
    assign phase_done = (phase_cnt == CTRL_PULSE_LEN);

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            curr       <= IDLE;
            phase_cnt  <= '0;
            read_cnt   <= '0;
            button_bit <= '0;
        end
        else if (clock_en) begin
            curr <= next;
            // Pins are active low
            button_bit <= {7'b0, ~ctlr_data};

            if (curr != next) begin
                phase_cnt <= '0;
            end
            else if (!phase_done) begin
                phase_cnt <= phase_cnt + 1'b1;
            end

            if (curr == WROTE1) begin
                read_cnt <= '0;
            end
            else if (curr != next && next == PULSE_HI) begin
                read_cnt <= read_cnt + 4'd1;
            end
        end
    end

    always_comb begin
        next = curr;
        // Strobe high restarts the sequence from anywhere
        if (joy_wr && bus.w_data[0]) begin
            next = WROTE1;
        end
        else begin
            case (curr)
                IDLE: next = IDLE;
                WROTE1: begin
                    if (joy_wr) begin
                        next = WROTE0;
                    end
                end
                WROTE0: begin
                    if (joy_rd) begin
                        next = PULSE_LO;
                    end
                end
                PULSE_LO: begin
                    if (phase_done) begin
                        next = PULSE_HI;
                    end
                end
                PULSE_HI: begin
                    if (read_cnt == 4'd8 && phase_done) begin
                        next = IDLE;
                    end
                    else if (joy_rd) begin
                        next = PULSE_LO;
                    end
                end
                default: next = IDLE;
            endcase
        end
    end

    assign ctlr_latch = (curr == WROTE1);
    assign ctlr_pulse = (curr == PULSE_HI);

endmodule : joypad_port

/* src/read_return.sv */
`timescale 1ns/100ps

module read_return (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  clock_en,
    input  nes_bus_pkg::bus_sel_t sel,
    input  logic                  r_en,
    input  nes_bus_pkg::data_t    ram_data,
    input  nes_bus_pkg::data_t    rom_data,
    input  nes_bus_pkg::data_t    button_bit,
    input  nes_bus_pkg::data_t    reg_data_rd,
    output nes_bus_pkg::data_t    r_data
);
    import nes_bus_pkg::*;

    logic  last_joy_rd;
    logic  last_ppu;
    logic  last_ram_rd;
    logic  last_rom_rd;
    data_t mem_hold;

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            last_joy_rd <= 1'b0;
            last_ppu    <= 1'b0;
            last_ram_rd <= 1'b0;
            last_rom_rd <= 1'b0;
            mem_hold    <= '0;
        end
        else if (clock_en) begin
            last_joy_rd <= sel.joy_sel && r_en;
            last_ppu    <= sel.ppu_sel;
            last_ram_rd <= sel.ram_sel && r_en;
            last_rom_rd <= sel.prom_sel && r_en;
            // Keep the byte being returned now for later unmapped reads
            if (last_ram_rd) begin
                mem_hold <= ram_data;
            end
            else if (last_rom_rd) begin
                mem_hold <= rom_data;
            end
        end
    end

    always_comb begin
        if (last_joy_rd) begin
            r_data = button_bit;
        end
        else if (last_ppu) begin
            r_data = reg_data_rd;
        end
        else if (last_ram_rd) begin
            r_data = ram_data;
        end
        else if (last_rom_rd) begin
            r_data = rom_data;
        end
        else begin
            r_data = mem_hold;
        end
    end

endmodule : read_return

/* src/nes_bus.sv */
`timescale 1ns/100ps

module nes_bus (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   clock_en,
    input  nes_bus_pkg::cpu_bus_t  bus,
    output nes_bus_pkg::data_t     r_data,
    output nes_bus_pkg::ppu_port_t ppu,
    input  nes_bus_pkg::data_t     reg_data_rd,
    input  logic                   ctlr_data,
    output logic                   ctlr_latch,
    output logic                   ctlr_pulse
);
    import nes_bus_pkg::*;

    bus_sel_t sel;
    ppu_reg_t ppu_reg;
    data_t    ram_data;
    data_t    rom_data;
    data_t    button_bit;

    bus_decoder u_decoder (
        .addr    (bus.addr),
        .sel     (sel),
        .ppu_reg (ppu_reg)
    );

    // PPU sees the request in the same cycle
    assign ppu.reg_sel     = ppu_reg;
    assign ppu.reg_en      = sel.ppu_sel;
    assign ppu.reg_rw      = ~bus.r_en;
    assign ppu.reg_data_wr = bus.w_data;

    work_ram u_ram (
        .clock    (clock),
        .clock_en (clock_en),
        .sel      (sel.ram_sel),
        .r_en     (bus.r_en),
        .addr     (bus.addr[RAM_ADDR_W-1:0]),
        .w_data   (bus.w_data),
        .r_data   (ram_data)
    );

    prg_rom u_prom (
        .clock    (clock),
        .clock_en (clock_en),
        .addr     (bus.addr[PROM_ADDR_W-1:0]),
        .r_data   (rom_data)
    );

    joypad_port u_joy (
        .clock      (clock),
        .reset_n    (reset_n),
        .clock_en   (clock_en),
        .bus        (bus),
        .joy_sel    (sel.joy_sel),
        .ctlr_data  (ctlr_data),
        .ctlr_latch (ctlr_latch),
        .ctlr_pulse (ctlr_pulse),
        .button_bit (button_bit)
    );

    read_return u_ret (
        .clock       (clock),
        .reset_n     (reset_n),
        .clock_en    (clock_en),
        .sel         (sel),
        .r_en        (bus.r_en),
        .ram_data    (ram_data),
        .rom_data    (rom_data),
        .button_bit  (button_bit),
        .reg_data_rd (reg_data_rd),
        .r_data      (r_data)
    );

endmodule : nes_bus

/* verif/joypad_model.sv */
`timescale 1ns/100ps

module joypad_model (
    input  logic               ctlr_latch,
    input  logic               ctlr_pulse,
    input  nes_bus_pkg::data_t buttons,
    output logic               ctlr_data
);
    import nes_bus_pkg::*;

    // Button A sits in bit 0 and leaves first
    data_t shift_reg;

    initial begin
        shift_reg = '0;
    end

    // Parallel load on the strobe, next button on each rising clock pin
    always @(posedge ctlr_latch or posedge ctlr_pulse) begin
        if (ctlr_latch) begin
            shift_reg <= buttons;
        end
        else begin
            // Real pads report ones once all eight buttons are out
            shift_reg <= {1'b1, shift_reg[7:1]};
        end
    end

    // Pins are active low
    assign ctlr_data = ~shift_reg[0];

endmodule : joypad_model

/* verif/nes_bus_tb.sv */
`timescale 1ns/100ps

module nes_bus_tb;
    import nes_bus_pkg::*;

    localparam int    PERIOD     = 40;
    localparam int    RESET_CYC  = 10;
    localparam int    MAX_ROWS   = 64;
    localparam addr_t IDLE_ADDR  = 16'h5000;

    // One bus request and what it should produce
    typedef struct packed {
        addr_t     addr;
        logic      r_en;
        data_t     w_data;
        data_t     prd;
        logic      chk_rd;
        data_t     exp_rd;
        logic      chk_ppu;
        ppu_port_t exp_ppu;
        logic [7:0] idle;
        logic [7:0] off_len;
    } row_t;

    logic      clock;
    logic      reset_n;
    logic      clock_en;
    cpu_bus_t  bus;
    data_t     r_data;
    ppu_port_t ppu;
    data_t     reg_data_rd;
    logic      ctlr_data;
    logic      ctlr_latch;
    logic      ctlr_pulse;
    data_t     buttons;

    row_t   rows [MAX_ROWS];
    string  row_name [MAX_ROWS];
    data_t  rom_img [16];
    int     n_rows;
    int     total_cycles;
    logic   table_ready;
    string  cur_name;
    logic   cur_bad;
    int     n_tests;
    int     n_fail;
    int     n_mismatch;

    nes_bus dut (
        .clock       (clock),
        .reset_n     (reset_n),
        .clock_en    (clock_en),
        .bus         (bus),
        .r_data      (r_data),
        .ppu         (ppu),
        .reg_data_rd (reg_data_rd),
        .ctlr_data   (ctlr_data),
        .ctlr_latch  (ctlr_latch),
        .ctlr_pulse  (ctlr_pulse)
    );

    joypad_model u_joy_model (
        .ctlr_latch (ctlr_latch),
        .ctlr_pulse (ctlr_pulse),
        .buttons    (buttons),
        .ctlr_data  (ctlr_data)
    );

    always #(PERIOD/2) clock = ~clock;

    task automatic compare_value(input string what, input logic [15:0] exp,
                                 input logic [15:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", cur_name, what, exp, act);
            cur_bad = 1'b1;
            n_mismatch++;
        end
    endtask

    task automatic report_test();
        n_tests++;
        if (cur_bad) begin
            n_fail++;
        end
        $display("test %-18s %s", cur_name, cur_bad ? "fail" : "pass");
    endtask

    function automatic row_t make_row(input addr_t addr, input logic r_en, input data_t w_data,
                                      input logic chk_rd, input data_t exp_rd);
        row_t t;
        t = '0;
        t.addr   = addr;
        t.r_en   = r_en;
        t.w_data = w_data;
        t.chk_rd = chk_rd;
        t.exp_rd = exp_rd;
        return t;
    endfunction

    task automatic push_row(input string name, input row_t t);
        rows[n_rows]     = t;
        row_name[n_rows] = name;
        n_rows++;
        total_cycles += 1 + t.idle + t.off_len;
    endtask

    // PPU access with port fields checked in the request cycle
    task automatic add_ppu(input addr_t addr, input logic r_en, input data_t w_data,
                           input data_t prd, input ppu_reg_t reg_sel);
        row_t      t;
        ppu_port_t p;
        t = make_row(addr, r_en, w_data, r_en, prd);
        p.reg_sel     = reg_sel;
        p.reg_en      = 1'b1;
        p.reg_rw      = ~r_en;
        p.reg_data_wr = w_data;
        t.prd     = prd;
        t.chk_ppu = 1'b1;
        t.exp_ppu = p;
        push_row($sformatf("ppu %h", addr), t);
    endtask

    task automatic build_table();
        row_t t;
        int   i;
        t = make_row(16'h0123, 1'b0, 8'hA5, 1'b0, 8'h00);
        push_row("ram write 0123", t);
        t = make_row(16'h07FF, 1'b0, 8'h5A, 1'b0, 8'h00);
        push_row("ram write 07ff", t);
        // RAM traffic keeps the PPU port quiet
        t = make_row(16'h0123, 1'b1, 8'h00, 1'b1, 8'hA5);
        t.chk_ppu = 1'b1;
        push_row("ram read 0123", t);
        t = make_row(16'h0923, 1'b1, 8'h00, 1'b1, 8'hA5);
        push_row("ram mirror 0923", t);
        t = make_row(16'h07FF, 1'b1, 8'h00, 1'b1, 8'h5A);
        push_row("ram read 07ff", t);
        t = make_row(16'h1FFF, 1'b1, 8'h00, 1'b1, 8'h5A);
        push_row("ram mirror 1fff", t);
        for (i = 0; i < 16; i++) begin
            t = make_row(16'hC000 + i, 1'b1, 8'h00, 1'b1, rom_img[i]);
            push_row($sformatf("rom read %h", 16'hC000 + i), t);
        end
        t = make_row(16'hC005, 1'b0, 8'hFF, 1'b0, 8'h00);
        push_row("rom write c005", t);
        t = make_row(16'hC005, 1'b1, 8'h00, 1'b1, rom_img[5]);
        push_row("rom reread c005", t);
        add_ppu(16'h2000, 1'b0, 8'h10, 8'h00, PPUCTRL);
        add_ppu(16'h2001, 1'b1, 8'h11, 8'h81, PPUMASK);
        add_ppu(16'h2002, 1'b1, 8'h12, 8'h82, PPUSTATUS);
        add_ppu(16'h2003, 1'b0, 8'h13, 8'h00, OAMADDR);
        add_ppu(16'h2004, 1'b1, 8'h14, 8'h84, OAMDATA);
        add_ppu(16'h2005, 1'b0, 8'h15, 8'h00, PPUSCROLL);
        add_ppu(16'h2006, 1'b0, 8'h16, 8'h00, PPUADDR);
        add_ppu(16'h2007, 1'b1, 8'h17, 8'h87, PPUDATA);
        add_ppu(16'h3FFE, 1'b1, 8'h3E, 8'hC3, PPUADDR);
        add_ppu(16'h4014, 1'b0, 8'h02, 8'h00, OAMDMA);
        // Live PPU data, so a lost source flag would show
        t = make_row(16'h2002, 1'b1, 8'h00, 1'b1, 8'h92);
        t.prd = 8'h92;
        push_row("ppu read before off", t);
        // Stalled write must leave r_data on the last read
        t = make_row(16'h0123, 1'b0, 8'hEE, 1'b1, 8'h92);
        t.prd     = 8'h92;
        t.off_len = 2 + ($urandom() % 6);
        push_row("enable off write", t);
        t = make_row(16'h0123, 1'b1, 8'h00, 1'b1, 8'hA5);
        push_row("ram after off", t);
        t = make_row(16'h5000, 1'b1, 8'h00, 1'b1, 8'hA5);
        push_row("unmapped read 5000", t);
        t = make_row(JOY1_ADDR, 1'b0, 8'h01, 1'b0, 8'h00);
        t.idle = 2;
        push_row("joy strobe high", t);
        t = make_row(JOY1_ADDR, 1'b0, 8'h00, 1'b0, 8'h00);
        t.idle = 2;
        push_row("joy strobe low", t);
        for (i = 0; i < 8; i++) begin
            t = make_row(JOY1_ADDR, 1'b1, 8'h00, 1'b1, {7'b0, buttons[i]});
            t.idle = 8;
            push_row($sformatf("joy read %0d", i), t);
        end
    endtask

    task automatic drive_idle();
        bus.addr    = IDLE_ADDR;
        bus.r_en    = 1'b1;
        bus.w_data  = '0;
        reg_data_rd = '0;
        clock_en    = 1'b1;
    endtask

    // Called on and returns on a falling edge
    task automatic run_row(input int i);
        row_t t;
        t = rows[i];
        cur_name    = row_name[i];
        cur_bad     = 1'b0;
        bus.addr    = t.addr;
        bus.r_en    = t.r_en;
        bus.w_data  = t.w_data;
        reg_data_rd = t.prd;
        clock_en    = (t.off_len == 0);
        repeat ((t.off_len == 0) ? 1 : t.off_len) @(negedge clock);
        if (t.chk_ppu) begin
            compare_value("reg_en", t.exp_ppu.reg_en, ppu.reg_en);
            if (t.exp_ppu.reg_en) begin
                compare_value("reg_sel", t.exp_ppu.reg_sel, ppu.reg_sel);
                compare_value("reg_rw", t.exp_ppu.reg_rw, ppu.reg_rw);
                compare_value("reg_data_wr", t.exp_ppu.reg_data_wr, ppu.reg_data_wr);
            end
        end
        if (t.chk_rd) begin
            compare_value("r_data", t.exp_rd, r_data);
        end
        if (t.idle != 0) begin
            drive_idle();
            repeat (t.idle) @(negedge clock);
        end
        report_test();
    endtask

    initial begin
        clock       = 1'b0;
        reset_n     = 1'b0;
        table_ready = 1'b0;
        buttons     = '0;
        n_rows      = 0;
        n_tests     = 0;
        n_fail      = 0;
        n_mismatch  = 0;
        drive_idle();
        void'($urandom(32'h98ef13d2));
        buttons = data_t'($urandom());
        $readmemh(PROM_FILE, rom_img);
        total_cycles = RESET_CYC + 2;
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYC) @(negedge clock);
        reset_n  = 1'b1;
        cur_name = "reset";
        cur_bad  = 1'b0;
        compare_value("ctlr_latch", 1'b0, ctlr_latch);
        compare_value("ctlr_pulse", 1'b0, ctlr_pulse);
        compare_value("reg_en", 1'b0, ppu.reg_en);
        compare_value("r_data", 8'h00, r_data);
        report_test();

        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        drive_idle();
        @(negedge clock);

        $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
                 n_tests, n_tests - n_fail, n_fail, n_mismatch);
        if (n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Four periods of slack for every cycle the table needs
    initial begin
        longint limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = longint'(total_cycles) * 4 * PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : nes_bus_tb

/* prg_rom.hex */
// PRG ROM bytes from 0xC000 upward, one hex byte per line
4C
00
C0
A9
1F
8D
00
20
A2
FF
9A
E8
8E
01
20
60

/* all.f */
src/nes_bus_pkg.sv
src/bus_decoder.sv
src/work_ram.sv
src/prg_rom.sv
src/joypad_port.sv
src/read_return.sv
src/nes_bus.sv
verif/joypad_model.sv
verif/nes_bus_tb.sv

/* Bender.yml */
package:
  name: nes_bus

sources:
  - files:
      - src/nes_bus_pkg.sv
      - src/bus_decoder.sv
      - src/work_ram.sv
      - src/prg_rom.sv
      - src/joypad_port.sv
      - src/read_return.sv
      - src/nes_bus.sv
  - target: test
    files:
      - verif/joypad_model.sv
      - verif/nes_bus_tb.sv
